/* list.f */
verilog/cache_pkg.sv
verilog/data_array.sv
verilog/meta_data_array.sv
verilog/cache_toplevel.sv
verilog/miss_handler.sv
verilog/cache_subsystem.sv
verification/cache_checker.sv
verification/cache_tb.sv

/* verification/cache_checker.sv */
/* port protocol assertions, bound into cache_subsystem
 * nothing is checked while rst_n is low
 */
`default_nettype none

module cache_checker (
	input logic clk,
	input logic rst_n,
	input logic busy,
	input logic rd_done,
	input logic mem_req,
	input logic data_we // fill strobe into the data array
);

	int assert_fails = 0; // summed into the testbench result

	// line request is a single cycle strobe
	mem_req_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		mem_req |=> !mem_req)
		else begin
			$error("mem_req high for more than one cycle");
			assert_fails++;
		end

	// a read cannot finish in the cycle that asks memory for its line
	done_not_req: assert property (@(posedge clk) disable iff (!rst_n)
		!(rd_done && mem_req))
		else begin
			$error("rd_done and mem_req in the same cycle");
			assert_fails++;
		end

	// port strobes and fills only inside a request
	strobes_busy: assert property (@(posedge clk) disable iff (!rst_n)
		(rd_done || mem_req || data_we) |-> busy)
		else begin
			$error("rd_done, mem_req or a fill while not busy");
			assert_fails++;
		end

endmodule

bind cache_subsystem cache_checker u_checker (
	.clk(clk),
	.rst_n(rst_n),
	.busy(busy),
	.rd_done(rd_done),
	.mem_req(mem_req),
	.data_we(data_we)
);

`default_nettype wire

/* verification/cache_tb.sv */
/* testbench for cache_subsystem, acts as processor and as main memory
 * memory word = byte address ^ 16'h5a3c, strobes come 1 to 4 cycles apart
 */
`default_nettype none

module cache_tb;

	localparam int n_random = 300;
	localparam int n_directed = 40; // bound on the directed reads
	localparam int timeout_cycles = 20 * (n_random + n_directed) + 500;
	localparam int max_wait = 100; // loop steps allowed per read

	logic clk;
	logic rst_n;
	logic cpu_req;
	logic [15:0] cpu_addr;
	logic rd_done;
	logic [15:0] rd_data;
	logic busy;
	logic mem_req;
	logic [11:0] mem_line_addr;
	logic mem_valid;
	logic [15:0] mem_data;

	// model state per set and way
	bit m_valid [64][2];
	logic [5:0] m_tag [64][2];
	bit m_recent [64][2]; // 1 = used last in its set

	int errors = 0;
	int checks = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int errors_at_start = 0;
	int n_accepted = 0; // requests issued while idle
	int n_rd_done = 0;
	int cycle_cnt = 0;

	cache_subsystem u_dut (
		.clk(clk), .rst_n(rst_n),
		.cpu_req(cpu_req), .cpu_addr(cpu_addr),
		.rd_done(rd_done), .rd_data(rd_data), .busy(busy),
		.mem_req(mem_req), .mem_line_addr(mem_line_addr),
		.mem_valid(mem_valid), .mem_data(mem_data)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (rst_n && rd_done) begin
			n_rd_done <= n_rd_done + 1;
		end
	end

	// covers reset plus every read of every test
	initial begin
		wait (cycle_cnt >= timeout_cycles);
		$display("timeout: simulation still running after %0d cycles", timeout_cycles);
		$display("Some tests failed");
		$finish;
	end

	function automatic logic [15:0] mem_word(input logic [15:0] byte_addr);
		return byte_addr ^ 16'h5a3c;
	endfunction

	function automatic logic [15:0] make_addr(input logic [5:0] tag, input logic [5:0] s_idx,
		input logic [2:0] word);
		return {tag, s_idx, word, 1'b0};
	endfunction

	task automatic check(input string name, input logic [15:0] expected, input logic [15:0] got);
		checks++;
		if (expected !== got) begin
			$display("ERR %0t %s expected %h got %h", $time, name, expected, got);
			errors++;
		end
	endtask

	// hit or miss by tag, victim by the active low lru rule
	task automatic model_access(input logic [15:0] addr, output bit hit);
		logic [5:0] s_idx;
		logic [5:0] tag;
		int way;
		s_idx = addr[9:4];
		tag = addr[15:10];
		hit = 1'b0;
		way = 0;
		for (int w = 0; w < 2; w++) begin
			if (m_valid[s_idx][w] && (m_tag[s_idx][w] == tag)) begin
				hit = 1'b1;
				way = w;
			end
		end
		if (!hit) begin
			if (!m_recent[s_idx][0] && !m_recent[s_idx][1]) begin
				way = 0; // cold set
			end else begin
				way = m_recent[s_idx][0] ? 1 : 0; // the way not used last
			end
			m_valid[s_idx][way] = 1'b1;
			m_tag[s_idx][way] = tag;
		end
		m_recent[s_idx][way] = 1'b1;
		m_recent[s_idx][1 - way] = 1'b0;
	endtask

	// memory side of one line, words 0..7 in order
	task automatic serve_line(input logic [11:0] line, input bit poke);
		int w;
		int gap;
		w = 0;
		gap = $urandom_range(4, 1);
		while (w < 8) begin
			@(posedge clk);
			#1;
			cpu_req = poke && (w == 4); // must be dropped, handler is busy
			gap--;
			if (gap == 0) begin
				mem_valid = 1'b1;
				mem_data = mem_word({line, w[2:0], 1'b0});
				w++;
				gap = $urandom_range(4, 1);
			end else begin
				mem_valid = 1'b0;
			end
		end
		@(posedge clk);
		#1;
		mem_valid = 1'b0;
		cpu_req = 1'b0;
	endtask

	// one processor read, poke keeps cpu_req pulsing while busy
	task automatic run_read(input logic [15:0] addr, input bit poke, output bit saw_miss,
		output logic [15:0] data, output int latency);
		int steps;
		int acc_cycle;
		bit done;
		saw_miss = 1'b0;
		data = 'x;
		latency = 0;
		steps = 0;
		done = 1'b0;
		@(posedge clk);
		#1;
		cpu_req = 1'b1;
		cpu_addr = addr;
		@(posedge clk); // accepted on this edge
		#1;
		acc_cycle = cycle_cnt;
		n_accepted++;
		cpu_req = poke;
		if (poke) begin
			cpu_addr = addr ^ 16'hffff; // a different line, must not be served
		end
		while (!done && (steps < max_wait)) begin
			@(negedge clk);
			if (rd_done) begin
				done = 1'b1;
				data = rd_data;
				latency = cycle_cnt - acc_cycle + 1;
			end else if (mem_req) begin
				saw_miss = 1'b1;
				check("mem_line_addr", {4'h0, addr[15:4]}, {4'h0, mem_line_addr});
				serve_line(addr[15:4], poke);
			end else begin
				@(posedge clk);
				#1;
				cpu_req = 1'b0;
			end
			steps++;
		end
		if (!done) begin
			$display("read of address %h never returned rd_done", addr);
			errors++;
		end
		@(posedge clk);
		#1;
		cpu_req = 1'b0;
	endtask

	task automatic checked_read(input logic [15:0] addr, input bit poke, output bit hit);
		bit exp_hit;
		bit saw_miss;
		logic [15:0] data;
		int latency;
		model_access(addr, exp_hit);
		run_read(addr, poke, saw_miss, data, latency);
		hit = !saw_miss;
		check("rd_data", mem_word({addr[15:1], 1'b0}), data); // bit 0 ignored
		check("hit", 16'(exp_hit), 16'(hit));
		if (hit) begin
			check("hit latency", 16'd1, 16'(latency));
		end
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (errors != errors_at_start) begin
			tests_failed++;
			$display("test %0d %s: %0d errors", tests_run, name, errors - errors_at_start);
		end else begin
			$display("test %0d %s: ok", tests_run, name);
		end
		errors_at_start = errors;
	endtask

	task automatic test_reset();
		bit hit;
		@(negedge clk);
		check("busy", 16'd0, 16'(busy));
		check("rd_done", 16'd0, 16'(rd_done));
		check("mem_req", 16'd0, 16'(mem_req));
		checked_read(16'h1234, 1'b0, hit);
		check("first read hit", 16'd0, 16'(hit));
		finish_test("reset and first miss");
	endtask

	task automatic test_line_words();
		bit hit;
		logic [15:0] addr;
		checked_read(make_addr(6'h0a, 6'h11, 3'd3), 1'b0, hit);
		for (int w = 0; w < 8; w++) begin
			addr = make_addr(6'h0a, 6'h11, w[2:0]) | 16'(w[0]); // odd words set the lane bit
			checked_read(addr, 1'b0, hit);
			check("line word hit", 16'd1, 16'(hit));
		end
		finish_test("line words after fill");
	endtask

	task automatic test_lru();
		bit hit;
		checked_read(make_addr(6'h01, 6'h05, 3'd0), 1'b0, hit); // a
		checked_read(make_addr(6'h02, 6'h05, 3'd1), 1'b0, hit); // b
		checked_read(make_addr(6'h01, 6'h05, 3'd2), 1'b0, hit); // a again, b now oldest
		checked_read(make_addr(6'h03, 6'h05, 3'd2), 1'b0, hit); // c replaces b
		checked_read(make_addr(6'h01, 6'h05, 3'd5), 1'b0, hit);
		check("a hit after c", 16'd1, 16'(hit));
		checked_read(make_addr(6'h02, 6'h05, 3'd6), 1'b0, hit);
		check("b hit after c", 16'd0, 16'(hit));
		finish_test("lru victim");
	endtask

	task automatic test_set_isolation();
		bit hit;
		checked_read(make_addr(6'h07, 6'h30, 3'd0), 1'b0, hit);
		checked_read(make_addr(6'h08, 6'h30, 3'd0), 1'b0, hit);
		checked_read(make_addr(6'h07, 6'h31, 3'd1), 1'b0, hit);
		checked_read(make_addr(6'h09, 6'h31, 3'd1), 1'b0, hit);
		for (int t = 10; t < 13; t++) begin
			checked_read(make_addr(6'(t), 6'h30, 3'd4), 1'b0, hit); // thrash the neighbour
		end
		checked_read(make_addr(6'h07, 6'h31, 3'd7), 1'b0, hit);
		check("other set way 0 hit", 16'd1, 16'(hit));
		checked_read(make_addr(6'h09, 6'h31, 3'd2), 1'b0, hit);
		check("other set way 1 hit", 16'd1, 16'(hit));
		finish_test("set isolation");
	endtask

	task automatic test_random();
		bit hit;
		int n_hits;
		logic [15:0] addr;
		n_hits = 0;
		for (int i = 0; i < n_random; i++) begin
			addr = make_addr(6'h20 + 6'($urandom_range(3, 0)), 6'h38 + 6'($urandom_range(3, 0)),
				3'($urandom_range(7, 0)));
			addr[0] = 1'($urandom_range(1, 0));
			checked_read(addr, 1'b0, hit);
			n_hits += hit;
		end
		$display("random reads: %0d of %0d hit", n_hits, n_random);
		finish_test("random reads");
	endtask

	task automatic test_busy_drop();
		bit hit;
		int rd0;
		int acc0;
		rd0 = n_rd_done;
		acc0 = n_accepted;
		checked_read(make_addr(6'h15, 6'h20, 3'd0), 1'b1, hit); // miss with pokes
		checked_read(make_addr(6'h15, 6'h20, 3'd4), 1'b1, hit); // hit with a poke
		repeat (4) @(negedge clk);
		check("busy after pokes", 16'd0, 16'(busy));
		check("rd_done count", 16'(n_accepted - acc0), 16'(n_rd_done - rd0));
		finish_test("requests while busy");
	endtask

	initial begin : main
		rst_n = 1'b0;
		cpu_req = 1'b0;
		cpu_addr = '0;
		mem_valid = 1'b0;
		mem_data = '0;
		void'($urandom(32'he599));
		repeat (10) @(posedge clk);
		#1;
		rst_n = 1'b1;
		test_reset();
		test_line_words();
		test_lru();
		test_set_isolation();
		test_random();
		test_busy_drop();
		$display("%0d tests, %0d failed, %0d checks, %0d errors, %0d assertion failures",
			tests_run, tests_failed, checks, errors, u_dut.u_checker.assert_fails);
		if ((errors == 0) && (tests_failed == 0) && (u_dut.u_checker.assert_fails == 0)) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* verilog/cache_pkg.sv */
/* shared definitions for the 2-way read-only cache
 * address split is fixed at 6 tag / 6 set / 4 offset, so none of this is tunable
 */
`default_nettype none

package cache_pkg;

	// address split, byte address [15:10] tag, [9:4] set, [3:1] word, [0] ignored
	localparam int tag_w = 6;
	localparam int set_w = 6;
	localparam int word_sel_w = 3;

	localparam int words_per_line = 8; // 16-byte line of 16-bit words

	// operation code seen by cache_toplevel
	// the value 3 is never issued
	typedef enum logic [1:0] {
		op_read = 2'd0, // lookup and lru touch on hit
		op_fill = 2'd1, // one data word into the victim way
		op_tag_write = 2'd2 // commit tag, valid and lru for the victim
	} cache_op_e;

	// one metadata byte per set and way
	// lru_n is active low so a cleared array reads as a cold set
	typedef struct packed {
		logic valid; // bit 7
		logic lru_n; // bit 6, 1 = most recent
		logic [tag_w-1:0] tag; // bits 5:0
	} meta_fields_t;

	// the arrays only move bytes around
	// the lookup logic picks the byte apart
	typedef union packed {
		logic [7:0] raw;
		meta_fields_t fields;
	} meta_word_u;

	// request from the miss handler into the lookup logic
	typedef struct packed {
		logic [15:0] addr; // word field replaced by fill count on a fill
		cache_op_e op;
		logic en; // low means nothing happens this cycle
	} cache_req_t;

	// word written into the data array on op_fill
	typedef struct packed {
		logic [15:0] data;
	} fill_word_t;

endpackage

`default_nettype wire

/* verilog/cache_subsystem.sv */
/* read-only 2-way cache with its fill controller
 * the memory side sits outside, words arrive on mem_valid in line order
 */
`default_nettype none

module cache_subsystem (
	input logic clk,
	input logic rst_n,
	input logic cpu_req,
	input logic [15:0] cpu_addr,
	output logic rd_done,
	output logic [15:0] rd_data,
	output logic busy,
	output logic mem_req,
	output logic [11:0] mem_line_addr,
	input logic mem_valid,
	input logic [15:0] mem_data
);

	import cache_pkg::*;

	cache_req_t cache_req; // handler -> lookup
	fill_word_t fill_word; // memory word into the data array
	logic miss;
	logic [set_w-1:0] set_idx;
	logic [set_w:0] line_sel; // {way, set}
	logic [word_sel_w-1:0] word_sel;
	logic data_we;
	logic tag_we; // both ways written together
	logic [15:0] rd_word;
	meta_word_u meta_0, meta_1; // current entries
	meta_word_u meta_next_0, meta_next_1; // merged entries to write back

	miss_handler u_miss_handler (
		.clk(clk), .rst_n(rst_n),
		.cpu_req(cpu_req), .cpu_addr(cpu_addr), .miss(miss),
		.mem_valid(mem_valid), .mem_data(mem_data),
		.cache_req(cache_req), .fill_word(fill_word),
		.rd_done(rd_done), .busy(busy),
		.mem_req(mem_req), .mem_line_addr(mem_line_addr)
	);

	cache_toplevel u_cache_toplevel (
		.req(cache_req), .meta_0(meta_0), .meta_1(meta_1), .rd_word(rd_word),
		.miss(miss), .rd_data(rd_data),
		.set_idx(set_idx), .line_sel(line_sel), .word_sel(word_sel),
		.data_we(data_we), .tag_we(tag_we),
		.meta_next_0(meta_next_0), .meta_next_1(meta_next_1)
	);

	data_array u_data_array (
		.clk(clk), .rst_n(rst_n),
		.line_sel(line_sel), .word_sel(word_sel),
		.we(data_we), .wdata(fill_word), .rdata(rd_word)
	);

	meta_data_array u_meta_way0 (
		.clk(clk), .rst_n(rst_n), .set_idx(set_idx),
		.we(tag_we), .wmeta(meta_next_0), .rmeta(meta_0)
	);

	meta_data_array u_meta_way1 (
		.clk(clk), .rst_n(rst_n), .set_idx(set_idx),
		.we(tag_we), .wmeta(meta_next_1), .rmeta(meta_1)
	);

endmodule

`default_nettype wire

/* verilog/cache_toplevel.sv */
/* combinational lookup for the 2-way cache, no clock inside
 * victim is way 0 on a cold set, otherwise the way with lru_n low
 * metadata of a set must not change between the miss and its tag write
 */
`default_nettype none

module cache_toplevel (
	input cache_pkg::cache_req_t req,
	input cache_pkg::meta_word_u meta_0, // way 0 entry for this set
	input cache_pkg::meta_word_u meta_1, // way 1 entry for this set
	input logic [15:0] rd_word,
	output logic miss,
	output logic [15:0] rd_data,
	output logic [cache_pkg::set_w-1:0] set_idx,
	output logic [cache_pkg::set_w:0] line_sel,
	output logic [cache_pkg::word_sel_w-1:0] word_sel,
	output logic data_we,
	output logic tag_we,
	output cache_pkg::meta_word_u meta_next_0,
	output cache_pkg::meta_word_u meta_next_1
);

	import cache_pkg::*;

	logic [tag_w-1:0] tag_in; // tag of the current address
	logic hit_0; // way 0 holds the line
	logic hit_1; // way 1 holds the line
	logic hit;
	logic [1:0] lrus_n; // {way 1, way 0}
	logic victim; // way chosen for eviction
	logic sel_way; // way the data array looks at
	logic install; // tag write cycle
	logic touch_lru; // lru is rewritten this cycle

	// next byte for one way
	// chosen marks the way that was just used or just installed
	function automatic meta_word_u next_meta(
		input meta_word_u cur,
		input logic chosen,
		input logic inst,
		input logic touch,
		input logic [tag_w-1:0] new_tag
	);
		meta_word_u nxt;
		nxt = cur;
		if (inst && chosen) begin
			nxt.fields.valid = 1'b1; // stays valid until reset
			nxt.fields.tag = new_tag;
		end
		if (touch) begin
			nxt.fields.lru_n = chosen; // other way drops to least recent
		end
		return nxt;
	endfunction

	// address split
	assign tag_in = req.addr[15 -: tag_w];
	assign set_idx = req.addr[4 +: set_w];
	assign word_sel = req.addr[1 +: word_sel_w]; // bit 0 is the byte lane, unused

	// both tags compared in parallel
	assign hit_0 = meta_0.fields.valid && (meta_0.fields.tag == tag_in);
	assign hit_1 = meta_1.fields.valid && (meta_1.fields.tag == tag_in);
	assign hit = req.en && (hit_0 || hit_1);
	assign miss = req.en && !(hit_0 || hit_1);

	// 00 cold -> way 0, 10 -> way 0, 01 -> way 1
	assign lrus_n = {meta_1.fields.lru_n, meta_0.fields.lru_n};
	assign victim = (lrus_n == 2'b01);

	// reads look at the hit way, fills and tag writes at the victim
	assign sel_way = (req.op == op_read) ? hit_1 : victim;
	assign line_sel = {sel_way, set_idx};

	assign rd_data = rd_word; // data array output is the read result

	// write strobes
	assign data_we = req.en && (req.op == op_fill);
	assign install = req.en && (req.op == op_tag_write);
	assign touch_lru = install || (hit && (req.op == op_read));
	assign tag_we = touch_lru; // a read miss and a fill leave metadata alone

	assign meta_next_0 = next_meta(meta_0, !sel_way, install, touch_lru, tag_in);
	assign meta_next_1 = next_meta(meta_1, sel_way, install, touch_lru, tag_in);

endmodule

`default_nettype wire

/* verilog/data_array.sv */
/* line storage for both ways, way 0 at lines 0..63 and way 1 at lines 64..127
 * read is combinational, one word written per clock, contents undefined after reset
 */
`default_nettype none

module data_array (
	input logic clk,
	input logic rst_n,
	input logic [cache_pkg::set_w:0] line_sel, // {way, set}
	input logic [cache_pkg::word_sel_w-1:0] word_sel,
	input logic we,
	input cache_pkg::fill_word_t wdata,
	output logic [15:0] rdata
);

	import cache_pkg::*;

	// 128 lines x 8 words
	logic [15:0] lines [1 << (set_w + 1)][words_per_line];

	// selected word straight out, no read latency
	assign rdata = lines[line_sel][word_sel];

	always_ff @(posedge clk) begin
		if (rst_n && we) begin // a stray strobe in reset writes nothing
			lines[line_sel][word_sel] <= wdata.data;
		end
	end

endmodule

`default_nettype wire

/* verilog/meta_data_array.sv */
/* valid, lru and tag of every set for one way
 * reset clears all 64 entries, which leaves every set cold
 */
`default_nettype none

module meta_data_array (
	input logic clk,
	input logic rst_n,
	input logic [cache_pkg::set_w-1:0] set_idx,
	input logic we,
	input cache_pkg::meta_word_u wmeta,
	output cache_pkg::meta_word_u rmeta
);

	import cache_pkg::*;

	logic [$bits(meta_word_u)-1:0] entries [1 << set_w]; // one byte per set

	// read the set being looked up in the same cycle
	always_comb begin
		rmeta.raw = entries[set_idx];
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < (1 << set_w); i++) begin
				entries[i] <= '0; // invalid, lru_n low
			end
		end else if (we) begin
			entries[set_idx] <= wmeta.raw; // whole byte, caller merges fields
		end
	end

endmodule

`default_nettype wire

/* verilog/miss_handler.sv */
/* processor side FSM and line fill sequencer, one miss in flight
 * memory must return words 0..7 in order, one mem_valid each, after mem_req
 * a cpu_req while busy is dropped
 */
`default_nettype none

module miss_handler (
	input logic clk,
	input logic rst_n,
	input logic cpu_req, // one cycle pulse
	input logic [15:0] cpu_addr,
	input logic miss,
	input logic mem_valid,
	input logic [15:0] mem_data,
	output cache_pkg::cache_req_t cache_req,
	output cache_pkg::fill_word_t fill_word,
	output logic rd_done,
	output logic busy,
	output logic mem_req,
	output logic [11:0] mem_line_addr
);

	import cache_pkg::*;

	typedef enum logic [2:0] {
		s_idle,
		s_lookup, // op_read, hit ends the request
		s_request, // mem_req pulse
		s_fill, // op_fill per mem_valid
		s_tag_write // commit the line
	} state_e;

	state_e state;
	state_e state_nxt;
	logic [15:0] addr_q; // address of the request in flight
	logic [word_sel_w-1:0] fill_cnt; // next word expected from memory
	logic last_word;

	assign last_word = mem_valid && (fill_cnt == word_sel_w'(words_per_line - 1));

	always_comb begin
		state_nxt = state;
		unique case (state)
			s_idle: if (cpu_req) state_nxt = s_lookup;
			s_lookup: state_nxt = miss ? s_request : s_idle;
			s_request: state_nxt = s_fill;
			s_fill: if (last_word) state_nxt = s_tag_write;
			s_tag_write: state_nxt = s_lookup; // second lookup now hits
			default: state_nxt = s_idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= s_idle;
			fill_cnt <= '0;
		end else begin
			state <= state_nxt;
			if (state == s_request) begin
				fill_cnt <= '0;
			end else if ((state == s_fill) && mem_valid) begin
				fill_cnt <= fill_cnt + 1'b1; // wraps to 0 after word 7
			end
		end
	end

	always_ff @(posedge clk) begin
		if ((state == s_idle) && cpu_req) begin
			addr_q <= cpu_addr;
		end
	end

	// request to the lookup logic
	always_comb begin
		cache_req.addr = addr_q;
		cache_req.op = op_read;
		cache_req.en = 1'b0;
		unique case (state)
			s_lookup: cache_req.en = 1'b1;
			s_fill: begin
				cache_req.addr = {addr_q[15:4], fill_cnt, 1'b0}; // word from the count
				cache_req.op = op_fill;
				cache_req.en = mem_valid; // write only on a strobe
			end
			s_tag_write: begin
				cache_req.op = op_tag_write;
				cache_req.en = 1'b1;
			end
			default: cache_req.en = 1'b0;
		endcase
	end

	assign fill_word.data = mem_data;
	assign rd_done = (state == s_lookup) && !miss; // same cycle as the lru write
	assign busy = (state != s_idle);
	assign mem_req = (state == s_request);
	assign mem_line_addr = addr_q[15:4]; // tag and set

endmodule

`default_nettype wire
